//--- src/rv_pkg.sv
// RV32I slice package: widths, opcodes, function codes, decoded-info union, stage packets
package rv_pkg;

	localparam int XLEN        = 32;
	localparam int INSTR_W     = 32;
	localparam int RFIDX_MAX_W = 5;

	// ==============================
	// Major opcodes
	// ==============================
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	// ALU funct3
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// Branch funct3
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// The ALT funct7 selects SUB and SRA
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	// ==============================
	// Decoded info
	// ==============================
	typedef enum logic [3:0] {
		ADD, SUB, SLT, SLTU, XOR, SLL, SRL, SRA, OR, AND, LUI
	} alu_fn_e;

	typedef enum logic {
		ALU,
		BJP
	} grp_e;

	typedef struct packed {
		logic [1:0] rsvd;
		alu_fn_e    fn;
		logic       op2_imm;
		logic       op1_pc;
	} alu_info_t;

	typedef struct packed {
		logic jump;
		logic jalr;
		logic beq;
		logic bne;
		logic blt;
		logic bge;
		logic bltu;
		logic bgeu;
	} bjp_info_t;

	// One info word read according to the group
	typedef union packed {
		alu_info_t alu;
		bjp_info_t bjp;
	} dec_info_u;

	// ==============================
	// Stage packets
	// ==============================
	typedef struct packed {
		logic                   valid;
		grp_e                   grp;
		dec_info_u              info;
		logic [RFIDX_MAX_W-1:0] rd;
		logic                   rd_wen;
		logic                   illegal;
		logic [XLEN-1:0]        pc;
		logic [XLEN-1:0]        imm;
		logic [XLEN-1:0]        rs1_val;
		logic [XLEN-1:0]        rs2_val;
	} dec_pkt_t;

	typedef struct packed {
		logic                   valid;
		grp_e                   grp;
		logic [RFIDX_MAX_W-1:0] rd;
		logic                   rd_wen;
		logic                   illegal;
		logic [XLEN-1:0]        alu_res;
		logic                   taken;
		logic [XLEN-1:0]        target;
		logic [XLEN-1:0]        pc;
	} exe_pkt_t;

	typedef struct packed {
		logic                   valid;
		logic                   wen;
		logic [RFIDX_MAX_W-1:0] rd;
		logic [XLEN-1:0]        wdata;
		logic                   redirect;
		logic [XLEN-1:0]        target;
		logic                   illegal;
	} res_pkt_t;

endpackage

//--- src/rv_imm_gen.sv
// Immediate generator: sign-extended I, U, B and J immediates with one-hot selection
`timescale 1ns/1ns

module rv_imm_gen (
	input  logic [rv_pkg::INSTR_W-1:0] i_instr,
	input  logic                       i_sel_i,
	input  logic                       i_sel_u,
	input  logic                       i_sel_b,
	input  logic                       i_sel_j,
	output logic [rv_pkg::XLEN-1:0]    o_imm
);

	import rv_pkg::*;

	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_j;

	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};

	assign imm_u = {i_instr[31:12], 12'b0};

	// Branch offset with bit 0 always zero
	assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
			i_instr[30:25], i_instr[11:8], 1'b0};

	// Jump offset is 21 bits before extension
	assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
			i_instr[20], i_instr[30:21], 1'b0};

	// AND-OR mux gives zero when nothing is selected
	assign o_imm = ({XLEN{i_sel_i}} & imm_i)
			| ({XLEN{i_sel_u}} & imm_u)
			| ({XLEN{i_sel_b}} & imm_b)
			| ({XLEN{i_sel_j}} & imm_j);

endmodule

//--- src/rv_decode.sv
// Decode stage: opcode and function decode, legality checks, info union fill, stage register
`timescale 1ns/1ns

module rv_decode #(
	parameter int RFIDX_WIDTH = 5
) (
	input  logic                       clk,
	input  logic                       i_rst,
	input  logic                       i_valid,
	input  logic [rv_pkg::INSTR_W-1:0] i_instr,
	input  logic [rv_pkg::XLEN-1:0]    i_pc,
	input  logic [rv_pkg::XLEN-1:0]    i_rs1_val,
	input  logic [rv_pkg::XLEN-1:0]    i_rs2_val,
	output rv_pkg::dec_pkt_t           o_dec
);

	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [4:0] rd_idx;
	logic [4:0] rs1_idx;
	logic [4:0] rs2_idx;
	logic is_op, is_op_imm, is_lui, is_auipc;
	logic is_branch, is_jal, is_jalr;
	logic is_shift_imm, shift_f6_ok, shamt_ilgl;
	logic op_legal, op_imm_legal, branch_legal;
	logic alu_op, bjp_op;
	logic all0s1s_ilgl, index_ilgl, illegal;
	logic need_rd, need_rs1, need_rs2;
	logic [XLEN-1:0] imm;
	alu_fn_e   alu_fn;
	alu_info_t alu_info;
	bjp_info_t bjp_info;
	dec_pkt_t  dec_d;

	assign opcode  = i_instr[6:0];
	assign rd_idx  = i_instr[11:7];
	assign funct3  = i_instr[14:12];
	assign rs1_idx = i_instr[19:15];
	assign rs2_idx = i_instr[24:20];
	assign funct7  = i_instr[31:25];

	assign is_op     = (opcode == OPC_OP);
	assign is_op_imm = (opcode == OPC_OP_IMM);
	assign is_lui    = (opcode == OPC_LUI);
	assign is_auipc  = (opcode == OPC_AUIPC);
	assign is_branch = (opcode == OPC_BRANCH);
	assign is_jal    = (opcode == OPC_JAL);
	assign is_jalr   = (opcode == OPC_JALR);

	// ==============================
	// ALU group
	// ==============================
	assign is_shift_imm = is_op_imm & ((funct3 == F3_SLL) | (funct3 == F3_SR));
	// SRAI alone may use the ALT pattern in the upper six bits
	assign shift_f6_ok = (i_instr[31:26] == F7_BASE[6:1])
			| ((funct3 == F3_SR) & (i_instr[31:26] == F7_ALT[6:1]));
	// shamt[5] must stay zero on RV32
	assign shamt_ilgl = is_shift_imm & i_instr[25];

	assign op_imm_legal = is_op_imm & (~is_shift_imm | shift_f6_ok);
	assign op_legal = is_op & ((funct7 == F7_BASE)
			| ((funct7 == F7_ALT) & ((funct3 == F3_ADD_SUB) | (funct3 == F3_SR))));

	always_comb begin
		alu_fn = ADD;
		case (funct3)
			F3_ADD_SUB: alu_fn = (is_op & funct7[5]) ? SUB : ADD;
			F3_SLL:     alu_fn = SLL;
			F3_SLT:     alu_fn = SLT;
			F3_SLTU:    alu_fn = SLTU;
			F3_XOR:     alu_fn = XOR;
			F3_SR:      alu_fn = i_instr[30] ? SRA : SRL;
			F3_OR:      alu_fn = OR;
			F3_AND:     alu_fn = AND;
		endcase
		if (is_lui) begin
			alu_fn = LUI;
		end else if (is_auipc) begin
			alu_fn = ADD;
		end
	end

	assign alu_info.rsvd    = 2'b00;
	assign alu_info.fn      = alu_fn;
	assign alu_info.op2_imm = is_op_imm | is_lui | is_auipc;
	assign alu_info.op1_pc  = is_auipc;

	assign alu_op = op_legal | op_imm_legal | is_lui | is_auipc;

	// ==============================
	// Branch and jump group
	// ==============================
	assign bjp_info.jump = is_jal | is_jalr;
	assign bjp_info.jalr = is_jalr;
	assign bjp_info.beq  = is_branch & (funct3 == F3_BEQ);
	assign bjp_info.bne  = is_branch & (funct3 == F3_BNE);
	assign bjp_info.blt  = is_branch & (funct3 == F3_BLT);
	assign bjp_info.bge  = is_branch & (funct3 == F3_BGE);
	assign bjp_info.bltu = is_branch & (funct3 == F3_BLTU);
	assign bjp_info.bgeu = is_branch & (funct3 == F3_BGEU);

	// funct3 010 and 011 fall out here
	assign branch_legal = bjp_info.beq | bjp_info.bne | bjp_info.blt
			| bjp_info.bge | bjp_info.bltu | bjp_info.bgeu;
	assign bjp_op = is_jal | is_jalr | branch_legal;

	// ==============================
	// Register needs and legality
	// ==============================
	assign need_rd  = (rd_idx != 5'd0) & ~is_branch;
	assign need_rs1 = (rs1_idx != 5'd0) & ~(is_lui | is_auipc | is_jal);
	assign need_rs2 = (rs2_idx != 5'd0) & (is_branch | is_op);

	// Only bites with a reduced register file
	assign index_ilgl = (need_rd & ((rd_idx >> RFIDX_WIDTH) != 5'd0))
			| (need_rs1 & ((rs1_idx >> RFIDX_WIDTH) != 5'd0))
			| (need_rs2 & ((rs2_idx >> RFIDX_WIDTH) != 5'd0));

	assign all0s1s_ilgl = (i_instr == '0) | (i_instr == '1);

	assign illegal = all0s1s_ilgl | shamt_ilgl | index_ilgl | ~(alu_op | bjp_op);

	rv_imm_gen u_imm_gen (
		.i_instr (i_instr),
		.i_sel_i (is_op_imm | is_jalr),
		.i_sel_u (is_lui | is_auipc),
		.i_sel_b (is_branch),
		.i_sel_j (is_jal),
		.o_imm   (imm)
	);

	always_comb begin
		dec_d.valid = i_valid;
		dec_d.grp   = bjp_op ? BJP : ALU;
		if (bjp_op) begin
			dec_d.info.bjp = bjp_info;
		end else begin
			dec_d.info.alu = alu_info;
		end
		dec_d.rd      = RFIDX_MAX_W'(rd_idx[RFIDX_WIDTH-1:0]);
		dec_d.rd_wen  = need_rd & ~illegal;
		dec_d.illegal = illegal;
		dec_d.pc      = i_pc;
		dec_d.imm     = imm;
		dec_d.rs1_val = i_rs1_val;
		dec_d.rs2_val = i_rs2_val;
	end

	// Decode stage register
	always_ff @(posedge clk) begin
		o_dec <= dec_d;
		if (i_rst) begin
			o_dec.valid <= 1'b0;
		end
	end

endmodule

//--- src/rv_execute.sv
// Execute stage: ALU operand select and operation, branch compare, target adder
`timescale 1ns/1ns

module rv_execute (
	input  rv_pkg::dec_pkt_t i_dec,
	output rv_pkg::exe_pkt_t o_exe
);

	import rv_pkg::*;

	alu_info_t       alu;
	bjp_info_t       bjp;
	logic [XLEN-1:0] op1;
	logic [XLEN-1:0] op2;
	logic [4:0]      shamt;
	logic [XLEN-1:0] alu_res;
	logic            eq, lt, ltu;
	logic            cond;
	logic [XLEN-1:0] tgt_base;
	logic [XLEN-1:0] tgt_sum;

	// Same info word seen both ways
	assign alu = i_dec.info.alu;
	assign bjp = i_dec.info.bjp;

	// ==============================
	// ALU
	// ==============================
	assign op1   = alu.op1_pc ? i_dec.pc : i_dec.rs1_val;
	assign op2   = alu.op2_imm ? i_dec.imm : i_dec.rs2_val;
	assign shamt = op2[4:0];

	always_comb begin
		case (alu.fn)
			ADD:     alu_res = op1 + op2;
			SUB:     alu_res = op1 - op2;
			SLT:     alu_res = XLEN'($signed(op1) < $signed(op2));
			SLTU:    alu_res = XLEN'(op1 < op2);
			XOR:     alu_res = op1 ^ op2;
			SLL:     alu_res = op1 << shamt;
			SRL:     alu_res = op1 >> shamt;
			SRA:     alu_res = $unsigned($signed(op1) >>> shamt);
			OR:      alu_res = op1 | op2;
			AND:     alu_res = op1 & op2;
			LUI:     alu_res = op2;
			default: alu_res = '0;
		endcase
	end

	// ==============================
	// Branch and jump
	// ==============================
	assign eq  = (i_dec.rs1_val == i_dec.rs2_val);
	assign lt  = ($signed(i_dec.rs1_val) < $signed(i_dec.rs2_val));
	assign ltu = (i_dec.rs1_val < i_dec.rs2_val);

	assign cond = bjp.jump
			| (bjp.beq & eq)
			| (bjp.bne & ~eq)
			| (bjp.blt & lt)
			| (bjp.bge & ~lt)
			| (bjp.bltu & ltu)
			| (bjp.bgeu & ~ltu);

	// JALR adds to rs1 and drops bit 0
	assign tgt_base = bjp.jalr ? i_dec.rs1_val : i_dec.pc;
	assign tgt_sum  = tgt_base + i_dec.imm;

	assign o_exe.valid   = i_dec.valid;
	assign o_exe.grp     = i_dec.grp;
	assign o_exe.rd      = i_dec.rd;
	assign o_exe.rd_wen  = i_dec.rd_wen;
	assign o_exe.illegal = i_dec.illegal;
	assign o_exe.alu_res = alu_res;
	assign o_exe.taken   = (i_dec.grp == BJP) & cond;
	assign o_exe.target  = bjp.jalr ? {tgt_sum[XLEN-1:1], 1'b0} : tgt_sum;
	assign o_exe.pc      = i_dec.pc;

endmodule

//--- src/rv_result.sv
// Result stage: writeback value select, redirect, illegal masking, output register
`timescale 1ns/1ns

module rv_result (
	input  logic             clk,
	input  logic             i_rst,
	input  rv_pkg::exe_pkt_t i_exe,
	output rv_pkg::res_pkt_t o_res
);

	import rv_pkg::*;

	logic            is_bjp;
	logic            side_ok;
	logic [XLEN-1:0] link;
	res_pkt_t        res_d;

	assign is_bjp = (i_exe.grp == BJP);

	// No side effects from an empty slot or an illegal word
	assign side_ok = i_exe.valid & ~i_exe.illegal;

	// Return address for JAL and JALR
	assign link = i_exe.pc + XLEN'(4);

	always_comb begin
		res_d.valid    = i_exe.valid;
		res_d.wen      = side_ok & i_exe.rd_wen;
		res_d.rd       = i_exe.rd;
		res_d.wdata    = is_bjp ? link : i_exe.alu_res;
		res_d.redirect = side_ok & i_exe.taken;
		res_d.target   = i_exe.target;
		res_d.illegal  = i_exe.valid & i_exe.illegal;
	end

	// ==============================
	// Output register
	// ==============================
	always_ff @(posedge clk) begin
		o_res <= res_d;
		if (i_rst) begin
			o_res.valid    <= 1'b0;
			o_res.wen      <= 1'b0;
			o_res.redirect <= 1'b0;
			o_res.illegal  <= 1'b0;
		end
	end

endmodule

//--- src/rv_exu_top.sv
// Execute slice top: decode, execute and result stages, two-cycle latency
`timescale 1ns/1ns

module rv_exu_top #(
	parameter int RFIDX_WIDTH = 5
) (
	input  logic                       clk,
	input  logic                       i_rst,
	input  logic                       i_valid,
	input  logic [rv_pkg::INSTR_W-1:0] i_instr,
	input  logic [rv_pkg::XLEN-1:0]    i_pc,
	input  logic [rv_pkg::XLEN-1:0]    i_rs1_val,
	input  logic [rv_pkg::XLEN-1:0]    i_rs2_val,
	output rv_pkg::res_pkt_t           o_res
);

	import rv_pkg::*;

	dec_pkt_t dec_pkt;
	exe_pkt_t exe_pkt;

	// Registered decode in the first cycle
	rv_decode #(
		.RFIDX_WIDTH (RFIDX_WIDTH)
	) u_decode (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_valid   (i_valid),
		.i_instr   (i_instr),
		.i_pc      (i_pc),
		.i_rs1_val (i_rs1_val),
		.i_rs2_val (i_rs2_val),
		.o_dec     (dec_pkt)
	);

	// Combinational
	rv_execute u_execute (
		.i_dec (dec_pkt),
		.o_exe (exe_pkt)
	);

	// Registered result in the second cycle
	rv_result u_result (
		.clk   (clk),
		.i_rst (i_rst),
		.i_exe (exe_pkt),
		.o_res (o_res)
	);

endmodule

//--- tb/tb_rv_exu_sva.sv
// Bound assertions on the slice outputs: illegal masking, two-cycle valid, quiet reset
`timescale 1ns/1ns

module tb_rv_exu_sva (
	input logic             clk,
	input logic             i_rst,
	input logic             i_valid,
	input rv_pkg::res_pkt_t o_res
);

	int fail_cnt = 0;

	// An illegal word never writes or redirects
	illegal_quiet: assert property (@(posedge clk) disable iff (i_rst)
			o_res.illegal |-> (!o_res.wen && !o_res.redirect))
		else begin
			$error("wen or redirect set together with illegal");
			fail_cnt++;
		end

	// Fixed latency in both directions
	valid_latency: assert property (@(posedge clk) disable iff (i_rst)
			o_res.valid == $past(i_valid, 2))
		else begin
			$error("o_res.valid does not follow i_valid by two cycles");
			fail_cnt++;
		end

	reset_quiet: assert property (@(posedge clk)
			$past(i_rst) |-> !(o_res.valid || o_res.wen || o_res.redirect || o_res.illegal))
		else begin
			$error("outputs active while in reset");
			fail_cnt++;
		end

endmodule

bind rv_exu_top tb_rv_exu_sva u_sva (
	.clk     (clk),
	.i_rst   (i_rst),
	.i_valid (i_valid),
	.o_res   (o_res)
);

//--- tb/tb_rv_exu.sv
// Testbench for the execute slice: clock, reset, vector file reader, expected queue, checks
`timescale 1ns/1ns

module tb_rv_exu;

	import rv_pkg::*;

	localparam int    CLK_PERIOD = 40;
	localparam int    RST_CYCLES = 3;
	localparam int    SEED       = 20896;
	// Vectors from this id on are applied with no idle cycles
	localparam int    BURST_ID   = 90;
	localparam string DATA_FILE  = "tb/rv_exu_testdata.txt";

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [31:0] rs1;
		logic [31:0] rs2;
	} stim_t;

	typedef struct packed {
		logic [31:0] id;
		logic [31:0] cyc;
		logic        wen;
		logic [4:0]  rd;
		logic [31:0] wdata;
		logic        redirect;
		logic [31:0] target;
		logic        illegal;
	} expect_t;

	logic        clk;
	logic        i_rst;
	logic        i_valid;
	logic [31:0] i_instr;
	logic [31:0] i_pc;
	logic [31:0] i_rs1_val;
	logic [31:0] i_rs2_val;
	res_pkt_t    o_res;

	stim_t   stim_q[$];
	expect_t expect_q[$];
	expect_t pend_q[$];

	int   n_vec  = 0;
	int   n_done = 0;
	int   n_err  = 0;
	int   cyc    = 0;
	logic loaded = 1'b0;

	rv_exu_top #(
		.RFIDX_WIDTH (5)
	) DUT (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_valid   (i_valid),
		.i_instr   (i_instr),
		.i_pc      (i_pc),
		.i_rs1_val (i_rs1_val),
		.i_rs2_val (i_rs2_val),
		.o_res     (o_res)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// ==============================
	// Helpers
	// ==============================
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
			n_err++;
		end
	endtask

	task automatic load_vectors();
		int          fd;
		int          n;
		int          id;
		string       line;
		logic [31:0] instr, pc, rs1, rs2, wen, rd, wdata, redir, target, ilgl;
		stim_t       s;
		expect_t     e;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open vector file %s", DATA_FILE);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() < 2 || line.substr(0, 0) == "#") begin
					continue;
				end
				n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h", id, instr, pc,
						rs1, rs2, wen, rd, wdata, redir, target, ilgl);
				if (n == 11) begin
					s.instr    = instr;
					s.pc       = pc;
					s.rs1      = rs1;
					s.rs2      = rs2;
					e.id       = 32'(id);
					e.cyc      = '0;
					e.wen      = wen[0];
					e.rd       = rd[4:0];
					e.wdata    = wdata;
					e.redirect = redir[0];
					e.target   = target;
					e.illegal  = ilgl[0];
					stim_q.push_back(s);
					expect_q.push_back(e);
				end
			end
			$fclose(fd);
		end
		n_vec = stim_q.size();
	endtask

	// Drive one vector and queue what it should produce
	task automatic apply(input stim_t s, input expect_t e);
		expect_t p;
		@(negedge clk);
		i_valid   = 1'b1;
		i_instr   = s.instr;
		i_pc      = s.pc;
		i_rs1_val = s.rs1;
		i_rs2_val = s.rs2;
		p = e;
		p.cyc = 32'(cyc);
		pend_q.push_back(p);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			i_valid = 1'b0;
		end
	endtask

	task automatic compare(input expect_t e);
		int err_before;
		err_before = n_err;
		check("latency", 32'(cyc) - e.cyc, 32'd2);
		check("o_res.wen", 32'(o_res.wen), 32'(e.wen));
		check("o_res.redirect", 32'(o_res.redirect), 32'(e.redirect));
		check("o_res.illegal", 32'(o_res.illegal), 32'(e.illegal));
		// rd and wdata only mean something with a write
		if (e.wen) begin
			check("o_res.rd", 32'(o_res.rd), 32'(e.rd));
			check("o_res.wdata", o_res.wdata, e.wdata);
		end
		if (e.redirect) begin
			check("o_res.target", o_res.target, e.target);
		end
		if (n_err == err_before) begin
			$display("test %0d ok", e.id);
		end else begin
			$display("test %0d had errors", e.id);
		end
		n_done++;
	endtask

	// ==============================
	// Output side
	// ==============================
	always @(negedge clk) begin
		if (o_res.valid) begin
			if (pend_q.size() == 0) begin
				$display("Output valid at %0t with no instruction pending", $time);
				n_err++;
			end else begin
				compare(pend_q.pop_front());
			end
		end
	end

	initial begin
		wait (loaded);
		repeat (n_vec * 4 + 20) @(posedge clk);
		$display("Watchdog expired, %0d of %0d results seen", n_done, n_vec);
		$display("TB FAILED");
		$finish;
	end

	// ==============================
	// Stimulus
	// ==============================
	initial begin
		int gap;
		int k;
		void'($urandom(SEED));
		i_rst     = 1'b1;
		i_valid   = 1'b0;
		i_instr   = '0;
		i_pc      = '0;
		i_rs1_val = '0;
		i_rs2_val = '0;
		load_vectors();
		if (n_vec == 0) begin
			$display("No vectors read from %s", DATA_FILE);
			$display("TB FAILED");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (RST_CYCLES) @(posedge clk);
			@(negedge clk);
			i_rst = 1'b0;
			for (k = 0; k < n_vec; k++) begin
				apply(stim_q[k], expect_q[k]);
				if (expect_q[k].id >= BURST_ID) begin
					gap = 0;
				end else begin
					gap = $urandom_range(2, 0);
				end
				idle(gap);
			end
			idle(1);
			wait (n_done == n_vec);
			repeat (2) @(negedge clk);
			$display("Summary: %0d tests, %0d checked, %0d errors, %0d assertion failures",
					n_vec, n_done, n_err, DUT.u_sva.fail_cnt);
			if (n_err == 0 && DUT.u_sva.fail_cnt == 0) begin
				$display("TB PASSED");
			end else begin
				$display("TB FAILED");
			end
			$finish;
		end
	end

endmodule

//--- tb/rv_exu_testdata.txt
# id instr pc rs1 rs2 | expected: wen rd wdata redirect target illegal
# id is decimal, all other columns hex; ids from 90 on run back to back
1 003100B3 00000100 00000005 00000007 1 01 0000000C 0 00000000 0
2 40628233 00000104 00000003 00000005 1 04 FFFFFFFE 0 00000000 0
3 009423B3 00000108 FFFFFFFF 00000001 1 07 00000001 0 00000000 0
4 009433B3 0000010C FFFFFFFF 00000001 1 07 00000000 0 00000000 0
5 40C5D533 00000110 80000000 00000004 1 0A F8000000 0 00000000 0
6 00C5D533 00000114 80000000 00000004 1 0A 08000000 0 00000000 0
7 FFF10093 00000118 00000010 00000000 1 01 0000000F 0 00000000 0
8 7F037293 0000011C 12345678 00000000 1 05 00000670 0 00000000 0
9 4085D513 00000120 80001234 00000000 1 0A FF800012 0 00000000 0
10 ABCDE637 00000124 00000000 00000000 1 0C ABCDE000 0 00000000 0
11 00001697 00000200 00000000 00000000 1 0D 00001200 0 00000000 0
12 00208863 00000300 00000055 00000055 0 00 00000000 1 00000310 0
13 00209863 00000304 00000055 00000055 0 00 00000000 0 00000000 0
14 FE41CCE3 00000400 FFFFFFF0 00000001 0 00 00000000 1 000003F8 0
15 FE41ECE3 00000400 FFFFFFF0 00000001 0 00 00000000 0 00000000 0
16 FE41FCE3 00000400 FFFFFFF0 00000001 0 00 00000000 1 000003F8 0
17 001000EF 00000500 00000000 00000000 1 01 00000504 1 00000D00 0
18 003302E7 00000600 00001000 00000000 1 05 00000604 1 00001002 0
19 00000000 00000604 00000000 00000000 0 00 00000000 0 00000000 1
20 FFFFFFFF 00000608 00000000 00000000 0 00 00000000 0 00000000 1
21 02049413 0000060C 00000081 00000000 0 00 00000000 0 00000000 1
22 023100B3 00000610 00000003 00000004 0 00 00000000 0 00000000 1
23 300110F3 00000614 00000001 00000000 0 00 00000000 0 00000000 1
24 0FF0000F 00000618 00000000 00000000 0 00 00000000 0 00000000 1
25 00508013 0000061C 00000007 00000000 0 00 00000000 0 00000000 0
90 0F01E113 00000700 00000F00 00000000 1 02 00000FF0 0 00000000 0
91 005241B3 00000704 FFFF0000 0F0F0F0F 1 03 F0F00F0F 0 00000000 0
92 001000EF 00000708 00000000 00000000 1 01 0000070C 1 00000F08 0
93 00839333 0000070C 00000001 00000025 1 06 00000020 0 00000000 0

//--- flist.f
src/rv_pkg.sv
src/rv_imm_gen.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_exu_top.sv
tb/tb_rv_exu_sva.sv
tb/tb_rv_exu.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_rv_exu
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
RUN_ARGS  := +verilator+error+limit+100
PASS_MSG  := TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$($(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
